//--- filelist.f
+incdir+.
sobelPixelPkg.sv
sobelCfgPkg.sv
sobelControl.sv
sobelLineBuffer.sv
sobelGradient.sv
sobelEdgePacker.sv
sobelTop.sv
sobelTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sobelTb -f filelist.f -o sobelSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sobelSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "all tests passed" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- sobelTb.sv
`include "sobel_consts.svh"

module sobelTb;

    import sobelPixelPkg::*;
    import sobelCfgPkg::*;

    localparam int clockPeriod = 40;
    localparam logic [7:0] ciId = 8'd5;
    localparam int rows = 6;
    localparam int cols = 64;
    localparam int drainLimit = 8;
    // Reset, five frames with their sync gaps, and the register accesses
    localparam int stimCycles = 16 + 5 * (rows * (cols + 5) + 5 + drainLimit) + 48;
    localparam int timeoutLimit = 2 * stimCycles;

    logic        camClock = 1'b0;
    logic        rst = 1'b1;
    logic        hsync = 1'b0;
    logic        vsync = 1'b0;
    logic        validCamera = 1'b0;
    logic        ciStart = 1'b0;
    logic [7:0]  ciN = 8'd0;
    logic [31:0] ciValueA = 32'd0;
    logic [31:0] ciValueB = 32'd0;
    pixelT       camData = '0;
    logic [31:0] ciResult;
    logic        ciDone;
    logic        wordValid;
    edgeWordT    edgeWord;

    pixelT    frame [rows][cols];
    edgeWordT expectQ [$];
    edgeWordT nextExpected;
    integer   seed;
    int       cycleCount = 0;
    int       wordErrors = 0;
    int       missingWords = 0;
    int       regErrors = 0;

    sobelTop #(.customId(ciId)) i_sobelTop (.*);

    always #(clockPeriod / 2) camClock = ~camClock;

    function automatic int sampleAt(input int r, input int c);
        return int'(frame[r][c]);
    endfunction

    // Expected word for one group of a row, first pixel in the top bit
    function automatic edgeWordT referenceWord(input int r, input int group, input int th);
        edgeWordT word;
        int i;
        int c;
        int gx;
        int gy;
        word = '0;
        for (i = 0; i < `SOBEL_WORD_BITS; i++) begin
            c = group * `SOBEL_WORD_BITS + i;
            if (r >= 2 && c >= 2) begin
                gx = sampleAt(r - 2, c) + 2 * sampleAt(r - 1, c) + sampleAt(r, c)
                   - sampleAt(r - 2, c - 2) - 2 * sampleAt(r - 1, c - 2) - sampleAt(r, c - 2);
                gy = sampleAt(r - 2, c - 2) + 2 * sampleAt(r - 2, c - 1) + sampleAt(r - 2, c)
                   - sampleAt(r, c - 2) - 2 * sampleAt(r, c - 1) - sampleAt(r, c);
                gx = (gx < 0) ? -gx : gx;
                gy = (gy < 0) ? -gy : gy;
                word[`SOBEL_WORD_BITS - 1 - i] = (gx + gy > th);
            end
        end
        return word;
    endfunction

    // regSel sits in bits 12:10, write flag in bit 9
    function automatic logic [31:0] encodeOp(input logic [2:0] sel, input logic wr);
        return {19'd0, sel, wr, 9'd0};
    endfunction

    task automatic accessRegister(input logic [7:0] n, input logic [2:0] sel, input logic wr,
                                  input logic [31:0] valueB, input logic [31:0] expResult);
        @(negedge camClock);
        ciStart = 1'b1;
        ciN = n;
        ciValueA = encodeOp(sel, wr);
        ciValueB = valueB;
        #(clockPeriod / 4);
        assert (ciDone == (n == ciId) && ciResult == expResult) else begin
            regErrors++;
            $display("error at %0t: ciDone %b ciResult %h, expected %b %h",
                     $time, ciDone, ciResult, n == ciId, expResult);
        end
    endtask

    task automatic endAccess();
        @(negedge camClock);
        ciStart = 1'b0;
    endtask

    task automatic writeThreshold(input logic [15:0] value);
        accessRegister(ciId, regThreshold, 1'b1, {16'ha5a5, value}, 32'd0);
        accessRegister(ciId, regThreshold, 1'b0, 32'd0, {16'd0, value});
        endAccess();
    endtask

    task automatic fillFrame(input logic flat);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                frame[r][c] = flat ? 8'd90 : pixelT'($random(seed));
            end
        end
    endtask

    task automatic runFrame(input int th);
        int waited;
        for (int r = 0; r < rows; r++) begin
            for (int g = 0; g < cols / `SOBEL_WORD_BITS; g++) begin
                expectQ.push_back(referenceWord(r, g, th));
            end
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                @(negedge camClock);
                validCamera = 1'b1;
                camData = frame[r][c];
            end
            @(negedge camClock);
            validCamera = 1'b0;
            repeat (3) @(negedge camClock);
            hsync = 1'b1;
            @(negedge camClock);
            hsync = 1'b0;
        end
        repeat (3) @(negedge camClock);
        vsync = 1'b1;
        @(negedge camClock);
        vsync = 1'b0;
        waited = 0;
        while (expectQ.size() != 0 && waited < drainLimit) begin
            @(posedge camClock);
            waited++;
        end
        assert (expectQ.size() == 0) else begin
            missingWords += expectQ.size();
            $display("%0d expected words never appeared", expectQ.size());
            expectQ.delete();
        end
    endtask

    // Words are checked in order against the queue
    always @(negedge camClock) begin
        if (wordValid) begin
            assert (expectQ.size() != 0) else begin
                wordErrors++;
                $display("word strobe at %0t with no word expected", $time);
            end
            if (expectQ.size() != 0) begin
                nextExpected = expectQ.pop_front();
                assert (edgeWord == nextExpected) else begin
                    wordErrors++;
                    $display("error at %0t: edge word %h, expected %h",
                             $time, edgeWord, nextExpected);
                end
            end
        end
    end

    always @(posedge camClock) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed = 3;
        repeat (16) @(negedge camClock);
        rst = 1'b0;

        // Threshold out of reset, then write and read back
        accessRegister(ciId, regThreshold, 1'b0, 32'd0, 32'd0);
        writeThreshold(16'h1234);
        // Other register select and a foreign instruction number
        accessRegister(ciId, 3'b010, 1'b0, 32'd0, 32'd0);
        accessRegister(ciId, 3'b010, 1'b1, 32'h55, 32'd0);
        accessRegister(8'd6, regThreshold, 1'b0, 32'd0, 32'd0);
        accessRegister(8'd6, regThreshold, 1'b1, 32'haa, 32'd0);
        accessRegister(ciId, regThreshold, 1'b0, 32'd0, 32'h1234);
        endAccess();

        fillFrame(1'b1);
        writeThreshold(16'd0);
        runFrame(0);

        fillFrame(1'b0);
        writeThreshold(16'd200);
        runFrame(200);
        writeThreshold(16'hffff);
        runFrame(65535);
        writeThreshold(16'd0);
        runFrame(0);

        // Line buffer still holds the previous frame here
        fillFrame(1'b0);
        writeThreshold(16'd200);
        runFrame(200);

        $display("errors: %0d word, %0d missing word, %0d register",
                 wordErrors, missingWords, regErrors);
        if (wordErrors + missingWords + regErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sobelTop.sv
module sobelTop #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic                    camClock,
    input  logic                    rst,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    validCamera,
    input  sobelPixelPkg::pixelT    camData,
    input  logic                    ciStart,
    input  logic [7:0]              ciN,
    input  logic [31:0]             ciValueA,
    input  logic [31:0]             ciValueB,
    output logic [31:0]             ciResult,
    output logic                    ciDone,
    output sobelPixelPkg::edgeWordT edgeWord,
    output logic                    wordValid
);

    import sobelPixelPkg::*;
    import sobelCfgPkg::*;

    logic      accept;
    colT       col;
    pixelTagT  pixelTag;
    thresholdT threshold;
    rowPairT   rowPair;
    logic      edgeBit;
    pixelTagT  edgeTag;

    sobelControl #(
        .customId(customId)
    ) i_sobelControl (
        .camClock   (camClock),
        .rst        (rst),
        .hsync      (hsync),
        .vsync      (vsync),
        .validCamera(validCamera),
        .ciStart    (ciStart),
        .ciN        (ciN),
        .ciValueA   (ciValueA),
        .ciValueB   (ciValueB),
        .ciResult   (ciResult),
        .ciDone     (ciDone),
        .accept     (accept),
        .col        (col),
        .pixelTag   (pixelTag),
        .threshold  (threshold)
    );

    sobelLineBuffer i_sobelLineBuffer (
        .camClock(camClock),
        .accept  (accept),
        .col     (col),
        .pixel   (camData),
        .rowPair (rowPair)
    );

    sobelGradient i_sobelGradient (
        .camClock (camClock),
        .rst      (rst),
        .accept   (accept),
        .pixel    (camData),
        .rowPair  (rowPair),
        .pixelTag (pixelTag),
        .threshold(threshold),
        .edgeBit  (edgeBit),
        .edgeTag  (edgeTag)
    );

    sobelEdgePacker i_sobelEdgePacker (
        .camClock (camClock),
        .rst      (rst),
        .hsync    (hsync),
        .vsync    (vsync),
        .edgeBit  (edgeBit),
        .edgeTag  (edgeTag),
        .edgeWord (edgeWord),
        .wordValid(wordValid)
    );

endmodule

//--- sobelEdgePacker.sv
`include "sobel_consts.svh"

module sobelEdgePacker (
    input  logic                    camClock,
    input  logic                    rst,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    edgeBit,
    input  sobelPixelPkg::pixelTagT edgeTag,
    output sobelPixelPkg::edgeWordT edgeWord,
    output logic                    wordValid
);

    import sobelPixelPkg::*;

    edgeWordT partial;
    edgeWordT nextWord;

    // First pixel of a group lands in the top bit
    assign nextWord = {partial[`SOBEL_WORD_BITS-2:0], edgeBit};

    always_ff @(posedge camClock) begin
        if (rst || hsync || vsync) begin
            partial <= '0;
        end else if (edgeTag.accept) begin
            partial <= nextWord;
        end
    end

    always_ff @(posedge camClock) begin
        if (edgeTag.accept && edgeTag.groupEnd) begin
            edgeWord <= nextWord;
        end
    end

    always_ff @(posedge camClock) begin
        if (rst) begin
            wordValid <= 1'b0;
        end else begin
            wordValid <= edgeTag.accept && edgeTag.groupEnd;
        end
    end

    // No line or frame end while a bit is still being packed
    syncAfterDrain: assert property (@(posedge camClock) disable iff (rst)
        (hsync || vsync) |-> !edgeTag.accept);

endmodule

//--- sobelGradient.sv
`include "sobel_consts.svh"

module sobelGradient (
    input  logic                    camClock,
    input  logic                    rst,
    input  logic                    accept,
    input  sobelPixelPkg::pixelT    pixel,
    input  sobelPixelPkg::rowPairT  rowPair,
    input  sobelPixelPkg::pixelTagT pixelTag,
    input  sobelCfgPkg::thresholdT  threshold,
    output logic                    edgeBit,
    output sobelPixelPkg::pixelTagT edgeTag
);

    import sobelPixelPkg::*;
    import sobelCfgPkg::*;

    // window[2] is the left (oldest) column, window[0] the right
    windowColT [2:0] window;
    windowColT       newCol;
    windowColT       leftCol;
    windowColT       midCol;
    windowColT       rightCol;

    gradT gradX;
    gradT gradY;
    logic [`SOBEL_GRAD_WIDTH-1:0] absX;
    logic [`SOBEL_GRAD_WIDTH-1:0] absY;
    thresholdT magnitude;

    // 1-2-1 weighted sum of three samples
    function automatic gradT weigh(pixelT a, pixelT b, pixelT c);
        gradT sum;
        sum = gradT'(a) + (gradT'(b) << 1) + gradT'(c);
        return sum;
    endfunction

    assign newCol = '{top: rowPair.above2, mid: rowPair.above1, bottom: pixel};

    always_ff @(posedge camClock) begin
        if (accept) begin
            window <= {window[1:0], newCol};
        end
    end

    assign leftCol = window[2];
    assign midCol = window[1];
    assign rightCol = window[0];

    assign gradX = weigh(rightCol.top, rightCol.mid, rightCol.bottom)
                 - weigh(leftCol.top, leftCol.mid, leftCol.bottom);
    assign gradY = weigh(leftCol.top, midCol.top, rightCol.top)
                 - weigh(leftCol.bottom, midCol.bottom, rightCol.bottom);

    assign absX = (gradX < 0) ? -gradX : gradX;
    assign absY = (gradY < 0) ? -gradY : gradY;

    // |Gx| + |Gy| tops out at 2040, well inside the threshold width
    assign magnitude = thresholdT'(absX) + thresholdT'(absY);

    always_ff @(posedge camClock) begin
        edgeBit <= pixelTag.inWindow && (magnitude > threshold);
    end

    always_ff @(posedge camClock) begin
        if (rst) begin
            edgeTag <= '0;
        end else begin
            edgeTag <= pixelTag;
        end
    end

endmodule

//--- sobelLineBuffer.sv
`include "sobel_consts.svh"

module sobelLineBuffer (
    input  logic                   camClock,
    input  logic                   accept,
    input  sobelPixelPkg::colT     col,
    input  sobelPixelPkg::pixelT   pixel,
    output sobelPixelPkg::rowPairT rowPair
);

    import sobelPixelPkg::*;

    rowPairT rowMem [`SOBEL_MAX_LINE];
    rowPairT writeData;

    // Read is combinational, the window needs it in the accepting cycle
    assign rowPair = rowMem[col];

    // New pixel becomes the row above, old row above moves up one
    assign writeData = '{above1: pixel, above2: rowPair.above1};

    always_ff @(posedge camClock) begin
        if (accept) begin
            rowMem[col] <= writeData;
        end
    end

endmodule

//--- sobelControl.sv
`include "sobel_consts.svh"

module sobelControl #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic                    camClock,
    input  logic                    rst,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    validCamera,
    input  logic                    ciStart,
    input  logic [7:0]              ciN,
    input  logic [31:0]             ciValueA,
    input  logic [31:0]             ciValueB,
    output logic [31:0]             ciResult,
    output logic                    ciDone,
    output logic                    accept,
    output sobelPixelPkg::colT      col,
    output sobelPixelPkg::pixelTagT pixelTag,
    output sobelCfgPkg::thresholdT  threshold
);

    import sobelCfgPkg::*;

    localparam int groupBits = $clog2(`SOBEL_WORD_BITS);

    logic [1:0] rowCount;
    logic       validInstr;
    logic       thresholdSel;
    ciOpT       ciOp;

    assign accept = validCamera;

    // Column and row position inside the frame
    always_ff @(posedge camClock) begin
        if (rst || vsync) begin
            col <= '0;
            rowCount <= 2'd0;
        end else if (hsync) begin
            col <= '0;
            // Only need to know when two full rows are stored
            if (rowCount != 2'd2) begin
                rowCount <= rowCount + 2'd1;
            end
        end else if (accept) begin
            col <= col + 1'b1;
        end
    end

    // Tag for the pixel taken at this edge
    always_ff @(posedge camClock) begin
        if (rst) begin
            pixelTag <= '0;
        end else begin
            pixelTag.accept <= accept;
            pixelTag.inWindow <= accept && rowCount == 2'd2 && col >= 2;
            pixelTag.groupEnd <= accept && col[groupBits-1:0] == '1;
        end
    end

    // Custom instruction decode
    assign ciOp = ciOpT'(ciValueA[12:9]);
    assign validInstr = ciStart && (ciN == customId);
    assign thresholdSel = validInstr && ciOp.regSel == regThreshold;
    assign ciDone = validInstr;
    assign ciResult = (thresholdSel && !ciOp.write) ? 32'(threshold) : 32'd0;

    always_ff @(posedge camClock) begin
        if (rst) begin
            threshold <= '0;
        end else if (thresholdSel && ciOp.write) begin
            threshold <= ciValueB[`SOBEL_THRESH_WIDTH-1:0];
        end
    end

    // Line ends only in an idle gap of the stream
    hsyncIdle: assert property (@(posedge camClock) disable iff (rst)
        hsync |-> !validCamera && !$past(validCamera));

endmodule

//--- sobelCfgPkg.sv
`include "sobel_consts.svh"

package sobelCfgPkg;

    // Operation field taken from ciValueA[12:9]
    typedef struct packed {
        logic [2:0] regSel;
        logic       write;
    } ciOpT;

    localparam logic [2:0] regThreshold = 3'b100;

    typedef logic [`SOBEL_THRESH_WIDTH-1:0] thresholdT;

endpackage

//--- sobelPixelPkg.sv
`include "sobel_consts.svh"

package sobelPixelPkg;

    typedef logic [`SOBEL_PIXEL_WIDTH-1:0] pixelT;

    // Samples from the two stored rows at one column
    typedef struct packed {
        pixelT above1;
        pixelT above2;
    } rowPairT;

    // One column of the 3x3 window, oldest row on top
    typedef struct packed {
        pixelT top;
        pixelT mid;
        pixelT bottom;
    } windowColT;

    typedef logic signed [`SOBEL_GRAD_WIDTH-1:0] gradT;

    typedef logic [`SOBEL_COL_WIDTH-1:0] colT;

    // Travels alongside a pixel through the pipeline
    typedef struct packed {
        logic accept;
        logic inWindow;
        logic groupEnd;
    } pixelTagT;

    typedef logic [`SOBEL_WORD_BITS-1:0] edgeWordT;

endpackage

//--- sobel_consts.svh
`ifndef SOBEL_CONSTS_SVH
`define SOBEL_CONSTS_SVH

// Camera sample width
`define SOBEL_PIXEL_WIDTH 8

// Line buffer depth, longest supported row
`define SOBEL_MAX_LINE 512
`define SOBEL_COL_WIDTH 9

// Edge bits packed per output word
`define SOBEL_WORD_BITS 32

`define SOBEL_GRAD_WIDTH 12
`define SOBEL_THRESH_WIDTH 16

`endif
